// File: source/periph_pkg.sv
// Peripheral bus package with request and response structs, slot numbers and register offsets
`default_nettype none

package periph_pkg;

    // Access size codes as presented by the core
    // Same encoding for reads and writes
    typedef enum logic [1:0] {
        acc_byte = 2'b00,
        acc_half = 2'b01,
        acc_word = 2'b10,
        acc_none = 2'b11
    } access_t;

    // Request from the core
    // Reads stay held until data_read_complete, writes last one cycle
    typedef struct packed {
        logic [10:0] addr;
        logic [31:0] wdata;
        access_t     write_n;
        access_t     read_n;
    } bus_req_t;

    // Response from one 64-byte slot, combinational from the current address
    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
    } slot_rsp_t;

    // User slot numbers, decoded from addr[9:6]
    localparam logic [3:0] slot_gpio    = 4'd1;
    localparam logic [3:0] slot_uart_tx = 4'd2;

    // GPIO register offsets, function selects follow at 0x20 to 0x3c
    localparam logic [5:0] gpio_off_out = 6'h00;
    localparam logic [5:0] gpio_off_in  = 6'h04;

    // UART transmitter register offsets
    localparam logic [5:0] uart_off_data   = 6'h00;
    localparam logic [5:0] uart_off_status = 6'h04;

endpackage

`default_nettype wire

// File: source/baud_timer.sv
// Baud timer that ticks on the last clock of every bit period while running
`timescale 1ns/10ps
`default_nettype none

module baud_timer #(
    parameter int clks_per_bit = 16
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  run,
    output logic tick
);

    // Counter needs at least one bit even for a period of one clock
    localparam int               cnt_w    = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

    logic [cnt_w-1:0] cnt;

    // Held at zero when idle so a new frame starts a full period
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tick = run && (cnt == cnt_last);

endmodule

`default_nettype wire

// File: source/uart_tx_shift.sv
// UART frame shift register driving the serial line, LSB first
`timescale 1ns/10ps
`default_nettype none

module uart_tx_shift (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        load,
    input  wire  [7:0] byte_in,
    input  wire        shift,
    output logic       tx
);

    // Stop bit at the top, start bit at the bottom
    logic [9:0] frame;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // All ones keeps the line at its idle level
            frame <= '1;
        end else if (load) begin
            frame <= {1'b1, byte_in, 1'b0};
        end else if (shift) begin
            // Fill with ones so the line rests high after the stop bit
            frame <= {1'b1, frame[9:1]};
        end
    end

    // Line is the bottom of the frame
    assign tx = frame[0];

endmodule

`default_nettype wire

// File: source/uart_tx_ctrl.sv
// UART transmitter control with frame FSM, busy status and frame-done interrupt
`timescale 1ns/10ps
`default_nettype none

module uart_tx_ctrl #(
    parameter int clks_per_bit = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  periph_pkg::bus_req_t  req,
    input  wire                         sel,
    output periph_pkg::slot_rsp_t       rsp,
    output logic                        tx,
    output logic                        interrupt
);

    import periph_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t     state;
    logic [2:0] bit_cnt;
    logic       busy;
    logic       tick;
    logic       data_wr;
    logic       load;

    assign busy    = (state != st_idle);
    assign data_wr = sel && (req.write_n != acc_none) && (req.addr[5:0] == uart_off_data);
    // Writes while a frame is in flight are dropped
    assign load    = data_wr && !busy;

    baud_timer #(
        .clks_per_bit (clks_per_bit)
    ) baud_timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (busy),
        .tick  (tick)
    );

    uart_tx_shift uart_tx_shift_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .byte_in (req.wdata[7:0]),
        .shift   (tick),
        .tx      (tx)
    );

    // One state per bit kind, data bits counted on ticks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            bit_cnt <= 3'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (load) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (tick) begin
                        state   <= st_data;
                        bit_cnt <= 3'd0;
                    end
                end
                st_data: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                        end
                    end
                end
                default: begin
                    // Busy drops as the stop bit ends
                    if (tick) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Frame done wins over a clearing write in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            interrupt <= 1'b0;
        end else if ((state == st_stop) && tick) begin
            interrupt <= 1'b1;
        end else if (data_wr) begin
            interrupt <= 1'b0;
        end
    end

    // Status word carries busy and interrupt
    always_comb begin
        rsp.ready = 1'b1;
        rsp.rdata = 32'h0;
        if (req.addr[5:0] == uart_off_status) begin
            rsp.rdata = {30'h0, interrupt, busy};
        end
    end

endmodule

`default_nettype wire

// File: source/gpio_regs.sv
// GPIO slot with output register, raw input readback and eight function-select registers
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  periph_pkg::bus_req_t  req,
    input  wire                         sel,
    input  wire  [7:0]                  ui_in,
    output periph_pkg::slot_rsp_t       rsp,
    output logic [7:0]                  gpio_out
);

    import periph_pkg::*;

    logic [5:0]  offset;
    logic        wr_en;
    logic        fsel_hit;
    logic [2:0]  fsel_idx;
    logic [31:0] func_sel [0:7];

    assign offset = req.addr[5:0];
    assign wr_en  = sel && (req.write_n != acc_none);

    // Word-aligned function selects in the upper half of the slot
    assign fsel_hit = offset[5] && (offset[1:0] == 2'b00);
    assign fsel_idx = offset[4:2];

    // Output pins, only the low byte of the write is used
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= 8'h00;
        end else if (wr_en && (offset == gpio_off_out)) begin
            gpio_out <= req.wdata[7:0];
        end
    end

    // Byte lanes written per access size
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                func_sel[i] <= 32'h0;
            end
        end else if (wr_en && fsel_hit) begin
            func_sel[fsel_idx][7:0] <= req.wdata[7:0];
            if ((req.write_n == acc_half) || (req.write_n == acc_word)) begin
                func_sel[fsel_idx][15:8] <= req.wdata[15:8];
            end
            if (req.write_n == acc_word) begin
                func_sel[fsel_idx][31:16] <= req.wdata[31:16];
            end
        end
    end

    // Reads never stall
    always_comb begin
        rsp.ready = 1'b1;
        rsp.rdata = 32'h0;
        if (offset == gpio_off_out) begin
            rsp.rdata = {24'h0, gpio_out};
        end else if (offset == gpio_off_in) begin
            rsp.rdata = {24'h0, ui_in};
        end else if (fsel_hit) begin
            rsp.rdata = func_sel[fsel_idx];
        end
    end

endmodule

`default_nettype wire

// File: source/periph_read_port.sv
// Read port that holds registered slot data for the core and generates data_ready
`timescale 1ns/10ps
`default_nettype none

module periph_read_port (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  periph_pkg::bus_req_t  req,
    input  wire  periph_pkg::slot_rsp_t rsp,
    input  wire                         data_read_complete,
    output logic [31:0]                 data_out,
    output logic                        data_ready
);

    import periph_pkg::*;

    logic read_req;
    logic last_read_req;
    logic data_hold;
    logic capture;

    assign read_req = (req.read_n != acc_none);

    // First ready cycle of a read while nothing is held
    assign capture = read_req && rsp.ready && !data_hold;

    // Read data, frozen until the core completes the read
    always_ff @(posedge clk) begin
        if (capture) begin
            data_out <= rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold     <= 1'b0;
            last_read_req <= 1'b0;
            data_ready    <= 1'b0;
        end else begin
            if (capture) begin
                data_hold <= 1'b1;
            end else if (data_read_complete) begin
                data_hold <= 1'b0;
            end
            last_read_req <= read_req;
            // One edge later than data_out so the core sees settled data
            data_ready    <= last_read_req && read_req && rsp.ready;
        end
    end

endmodule

`default_nettype wire

// File: source/periph_bus.sv
// Peripheral bus top, decodes the user slot and joins GPIO, UART transmitter and read port
`timescale 1ns/10ps
`default_nettype none

module periph_bus #(
    parameter int clks_per_bit = 16
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [7:0]                 ui_in,
    output logic [7:0]                 uo_out,
    input  wire  periph_pkg::bus_req_t req,
    output logic [31:0]                data_out,
    output logic                       data_ready,
    input  wire                        data_read_complete,
    output logic [15:2]                user_interrupts
);

    import periph_pkg::*;

    logic       user_space;
    logic [3:0] slot;
    logic       gpio_sel;
    logic       uart_sel;
    slot_rsp_t  gpio_rsp;
    slot_rsp_t  uart_rsp;
    slot_rsp_t  slot_rsp;
    logic [7:0] gpio_out;
    logic       uart_tx_line;
    logic       uart_irq;

    // Upper half of the 11-bit space is not populated
    assign user_space = !req.addr[10];
    assign slot       = req.addr[9:6];

    // One select line per populated slot
    assign gpio_sel = user_space && (slot == slot_gpio);
    assign uart_sel = user_space && (slot == slot_uart_tx);

    gpio_regs gpio_regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .sel      (gpio_sel),
        .ui_in    (ui_in),
        .rsp      (gpio_rsp),
        .gpio_out (gpio_out)
    );

    uart_tx_ctrl #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .sel       (uart_sel),
        .rsp       (uart_rsp),
        .tx        (uart_tx_line),
        .interrupt (uart_irq)
    );

    // Response and output pins follow the addressed slot
    // Empty slots read as zero and are always ready
    always_comb begin
        slot_rsp.rdata = 32'h0;
        slot_rsp.ready = 1'b1;
        uo_out         = 8'h00;
        if (gpio_sel) begin
            slot_rsp = gpio_rsp;
            uo_out   = gpio_out;
        end else if (uart_sel) begin
            slot_rsp = uart_rsp;
            uo_out   = {7'h00, uart_tx_line};
        end
    end

    // Interrupt bit index equals slot number
    always_comb begin
        user_interrupts               = '0;
        user_interrupts[slot_uart_tx] = uart_irq;
    end

    periph_read_port periph_read_port_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .rsp                (slot_rsp),
        .data_read_complete (data_read_complete),
        .data_out           (data_out),
        .data_ready         (data_ready)
    );

endmodule

`default_nettype wire

// File: tb/periph_bus_tb.sv
// Testbench for the peripheral bus covering GPIO, sized writes, read hold and UART transmit
`timescale 1ns/10ps
`default_nettype none

module periph_bus_tb;

    import periph_pkg::*;

    localparam int clks_per_bit = 16;
    localparam int wait_limit   = 64;

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    logic [7:0]  uo_out;
    bus_req_t    req;
    logic [31:0] data_out;
    logic        data_ready;
    logic        data_read_complete;
    logic [15:2] user_interrupts;

    logic [31:0] lfsr_state;
    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          test_errors = 0;

    periph_bus #(
        .clks_per_bit (clks_per_bit)
    ) periph_bus_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .ui_in              (ui_in),
        .uo_out             (uo_out),
        .req                (req),
        .data_out           (data_out),
        .data_ready         (data_ready),
        .data_read_complete (data_read_complete),
        .user_interrupts    (user_interrupts)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Edge counter for bit-centre timing
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // data_ready falls one edge after the read request is released
    assert property (@(posedge clk) disable iff (!rst_n)
        (req.read_n == acc_none) |=> !data_ready)
    else begin
        $display("[FAIL] %0t data_ready got 1 expected 0", $time);
        errors++;
    end

    // Only the UART slot has an interrupt source
    assert property (@(posedge clk) disable iff (!rst_n) user_interrupts[15:3] == '0)
    else begin
        $display("[FAIL] %0t user_interrupts[15:3] got %h expected 0", $time,
                 user_interrupts[15:3]);
        errors++;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken, newest bit in the LSB
    task automatic random_bits(input int nbits, output logic [31:0] value);
        value = 32'h0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Sized write reference, the written lanes replace the old ones
    function automatic logic [31:0] merge_lanes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input access_t     size);
        logic [31:0] mask;
        case (size)
            acc_byte: mask = 32'h0000_00ff;
            acc_half: mask = 32'h0000_ffff;
            acc_word: mask = 32'hffff_ffff;
            default:  mask = 32'h0;
        endcase
        return (old & ~mask) | (wdata & mask);
    endfunction

    // Frame bit k: start low, data LSB first, stop high
    function automatic logic frame_bit(input logic [7:0] data, input int k);
        if (k == 0) begin
            return 1'b0;
        end else if (k == 9) begin
            return 1'b1;
        end
        return data[k-1];
    endfunction

    function automatic logic [10:0] slot_addr(input logic [3:0] slot, input logic [5:0] offset);
        return {1'b0, slot, offset};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        errors++;
        $display("sim failed");
        $finish;
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s ok", tests_run, name);
        end else begin
            $display("test %0d %s failed with %0d errors", tests_run, name, errors - test_errors);
        end
    endtask

    // All bus tasks start and end on a falling edge
    task automatic bus_write(input logic [10:0] addr, input access_t size,
                             input logic [31:0] wdata);
        req.addr    = addr;
        req.wdata   = wdata;
        req.write_n = size;
        @(negedge clk);
        req.write_n = acc_none;
    endtask

    task automatic start_read(input logic [10:0] addr);
        req.addr   = addr;
        req.read_n = acc_word;
    endtask

    // data_ready is due two edges after the request
    task automatic wait_ready();
        int edges;
        edges = 0;
        while (!data_ready) begin
            @(negedge clk);
            edges++;
            if (edges > wait_limit) begin
                abort_run("data_ready never rose during a read");
            end
        end
        check_value("data_ready latency", edges, 32'd2);
    endtask

    // Request drops together with the completion pulse
    task automatic finish_read();
        req.read_n         = acc_none;
        data_read_complete = 1'b1;
        @(negedge clk);
        data_read_complete = 1'b0;
    endtask

    task automatic bus_read(input logic [10:0] addr, input string name,
                            input logic [31:0] exp);
        start_read(addr);
        wait_ready();
        check_value(name, data_out, exp);
        finish_read();
    endtask

    task automatic wait_until_cycle(input int target);
        int guard;
        guard = 0;
        while (cyc < target) begin
            @(negedge clk);
            guard++;
            if (guard > 4 * wait_limit) begin
                abort_run("bit centre never reached");
            end
        end
    endtask

    task automatic wait_uart_irq(input int limit);
        int guard;
        guard = 0;
        while (!user_interrupts[2]) begin
            @(negedge clk);
            guard++;
            if (guard > limit) begin
                abort_run("UART interrupt did not rise after the frame");
            end
        end
    endtask

    // Lanes merged into a running model, one step per size
    task automatic sized_write_check(input logic [10:0] addr, input access_t size,
                                     inout logic [31:0] model);
        logic [31:0] value;
        random_bits(32, value);
        bus_write(addr, size, value);
        model = merge_lanes(model, value, size);
        bus_read(addr, "data_out func_sel", model);
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] model;
        logic [10:0] fsel_addr;
        logic [7:0]  tx_byte;
        int          t0;
        lfsr_state         = 32'h5118_fa63;
        rst_n              = 1'b0;
        ui_in              = 8'h00;
        req                = '0;
        req.write_n        = acc_none;
        req.read_n         = acc_none;
        data_read_complete = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        check_value("data_ready", {31'h0, data_ready}, 32'h0);
        check_value("user_interrupts", {18'h0, user_interrupts}, 32'h0);
        check_value("uo_out", {24'h0, uo_out}, 32'h0);
        bus_read(slot_addr(4'd5, 6'h00), "data_out empty slot", 32'h0);
        end_test("reset state");

        begin_test();
        random_bits(8, value);
        bus_write(slot_addr(slot_gpio, gpio_off_out), acc_word, value);
        bus_read(slot_addr(slot_gpio, gpio_off_out), "data_out gpio_out", value);
        // Address still in slot 1 so the pins show the GPIO register
        check_value("uo_out", {24'h0, uo_out}, value);
        random_bits(8, value);
        ui_in = value[7:0];
        bus_read(slot_addr(slot_gpio, gpio_off_in), "data_out ui_in", value);
        end_test("gpio output");

        begin_test();
        random_bits(3, value);
        // Function selects at 0x20 plus four per register
        fsel_addr = {1'b0, slot_gpio, 1'b1, value[2:0], 2'b00};
        model     = 32'h0;
        sized_write_check(fsel_addr, acc_word, model);
        sized_write_check(fsel_addr, acc_byte, model);
        sized_write_check(fsel_addr, acc_half, model);
        sized_write_check(fsel_addr, acc_word, model);
        end_test("sized writes");

        begin_test();
        random_bits(8, value);
        ui_in = value[7:0];
        start_read(slot_addr(slot_gpio, gpio_off_in));
        wait_ready();
        check_value("data_out held", data_out, value);
        ui_in = ~value[7:0];
        repeat (4) begin
            @(negedge clk);
            check_value("data_out held", data_out, value);
        end
        finish_read();
        bus_read(slot_addr(slot_gpio, gpio_off_in), "data_out released", {24'h0, ~value[7:0]});
        end_test("read hold");

        begin_test();
        random_bits(8, value);
        tx_byte = value[7:0];
        bus_write(slot_addr(slot_uart_tx, uart_off_data), acc_byte, value);
        // t0 counts the edge that loads the frame
        t0 = cyc;
        for (int k = 0; k < 10; k++) begin
            wait_until_cycle(t0 + clks_per_bit / 2 + clks_per_bit * k);
            check_value("uo_out[0]", {31'h0, uo_out[0]}, {31'h0, frame_bit(tx_byte, k)});
            if (k == 1) begin
                bus_read(slot_addr(slot_uart_tx, uart_off_status), "data_out uart status", 32'h1);
            end
            if (k == 3) begin
                // Dropped while busy, later bits must still match tx_byte
                random_bits(8, value);
                bus_write(slot_addr(slot_uart_tx, uart_off_data), acc_byte, value);
            end
        end
        end_test("uart frame");

        begin_test();
        wait_uart_irq(wait_limit);
        check_value("interrupt edge", cyc - t0, 10 * clks_per_bit);
        repeat (20) begin
            @(negedge clk);
            check_value("user_interrupts[2]", {31'h0, user_interrupts[2]}, 32'h1);
        end
        bus_read(slot_addr(slot_uart_tx, uart_off_status), "data_out uart status", 32'h2);
        random_bits(8, value);
        bus_write(slot_addr(slot_uart_tx, uart_off_data), acc_byte, value);
        check_value("user_interrupts[2]", {31'h0, user_interrupts[2]}, 32'h0);
        bus_read(slot_addr(slot_uart_tx, uart_off_status), "data_out uart status", 32'h1);
        wait_uart_irq(12 * clks_per_bit);
        end_test("uart interrupt");

        $display("tests %0d checks %0d errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/periph_pkg.sv
source/baud_timer.sv
source/uart_tx_shift.sv
source/uart_tx_ctrl.sv
source/gpio_regs.sv
source/periph_read_port.sv
source/periph_bus.sv
tb/periph_bus_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = periph_bus_tb
RTL_TOP    = periph_bus
FILE_LIST  = sources.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The log decides the result, the exit code of the model is not used
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
